// File: dv/acoustics_tb.sv
// Acoustic capture testbench

`timescale 1ns/1ps

module acoustics_tb;

	localparam int TABLE_LEN         = 8;
	localparam int SAMPLES_PER_BLOCK = acoustics_pkg::BLOCK_WORDS / acoustics_pkg::WORDS_PER_SAMPLE;
	localparam int TOTAL_FRAMES      = 42;	// Frames and drdy pulses over all tests
	localparam longint WATCHDOG_NS   = TOTAL_FRAMES * 60 * 100 + 200000;

	logic                                    okClk = 1'b0;
	logic                                    reset_sclk;
	logic [acoustics_pkg::CTRL_W-1:0]        ctrl_in;
	logic                                    pipe_read;
	logic                                    drdy;
	logic                                    miso_pf;
	logic                                    miso_pa;
	logic                                    miso_sf;
	logic                                    miso_sa;
	logic                                    sclk_out;
	logic                                    start;
	logic                                    clk_out;
	logic [acoustics_pkg::WORD_W-1:0]        pipe_data;
	logic                                    pipe_ready;
	logic                                    overflow;
	logic [acoustics_pkg::LED_W-1:0]         led;
	logic [acoustics_pkg::BITS_PER_CH-1:0]   tbl_pf [TABLE_LEN];	// Stimulus table
	logic [acoustics_pkg::BITS_PER_CH-1:0]   tbl_pa [TABLE_LEN];
	logic [acoustics_pkg::BITS_PER_CH-1:0]   tbl_sf [TABLE_LEN];
	logic [acoustics_pkg::BITS_PER_CH-1:0]   tbl_sa [TABLE_LEN];
	int                                      seed = 88;
	int                                      test_errors;
	int                                      pass_count = 0;
	int                                      fail_count = 0;
	int                                      sclk_pulses = 0;

	always #50 okClk = ~okClk;	// 100 ns period
	always @(posedge sclk_out) sclk_pulses = sclk_pulses + 1;

	acoustics_top u_acoustics_top (
		.okClk (okClk), .reset_sclk (reset_sclk), .ctrl_in (ctrl_in), .drdy_in (drdy),
		.miso_pf_in (miso_pf), .miso_pa_in (miso_pa), .miso_sf_in (miso_sf),
		.miso_sa_in (miso_sa), .pipe_read (pipe_read), .sclk_out (sclk_out),
		.start (start), .clk_out (clk_out), .pipe_data (pipe_data),
		.pipe_ready (pipe_ready), .overflow (overflow), .led (led)
	);

	adc_model u_adc_model (
		.okClk (okClk), .sclk (sclk_out), .drdy (drdy), .miso_pf (miso_pf),
		.miso_pa (miso_pa), .miso_sf (miso_sf), .miso_sa (miso_sa)
	);

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------
	function automatic acoustics_pkg::sample_t expected_sample(input int idx);
		return {tbl_pf[idx], tbl_pa[idx], tbl_sf[idx], tbl_sa[idx]};	// PF on top
	endfunction

	task automatic check_bit(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
			test_errors++;
		end
	endtask

	task automatic set_ctrl(input logic [acoustics_pkg::CTRL_W-1:0] value);
		@(posedge okClk);
		ctrl_in <= value;
		repeat (2) @(posedge okClk);	// One cycle to register, one to act
		@(negedge okClk);
	endtask

	task automatic send_frames(input int first, input int n);
		int idx;
		for (int k = 0; k < n; k++) begin
			idx = (first + k) % TABLE_LEN;
			u_adc_model.send_frame(tbl_pf[idx], tbl_pa[idx], tbl_sf[idx], tbl_sa[idx]);
		end
		@(negedge okClk);
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		@(negedge okClk);
		while (!pipe_ready && n < 200) begin
			@(negedge okClk);
			n++;
		end
		if (!pipe_ready) begin
			$display("pipe_ready did not rise within 200 cycles at %0t ns", $time);
			test_errors++;
		end
	endtask

	// Back-to-back reads with each word checked before the edge that takes it
	task automatic read_block(input int first);
		acoustics_pkg::sample_t           smp;
		logic [acoustics_pkg::WORD_W-1:0] exp_word;
		for (int s = 0; s < SAMPLES_PER_BLOCK; s++) begin
			smp = expected_sample((first + s) % TABLE_LEN);
			for (int w = 0; w < acoustics_pkg::WORDS_PER_SAMPLE; w++) begin
				exp_word = smp[acoustics_pkg::SAMPLE_W - 1 - w * acoustics_pkg::WORD_W
				               -: acoustics_pkg::WORD_W];
				@(posedge okClk);
				pipe_read <= 1'b1;
				@(negedge okClk);
				if (pipe_data !== exp_word) begin
					$display("Error at %0t ns: word %0d of sample %0d is %h, expected %h",
					         $time, w, s, pipe_data, exp_word);
					test_errors++;
				end
			end
		end
		@(posedge okClk);
		pipe_read <= 1'b0;
		@(posedge okClk);	// pipe_ready is registered
		@(negedge okClk);
	endtask

	task automatic end_test(input int num, input string name);
		if (test_errors == 0) begin
			pass_count++;
			$display("Test %0d %s: pass", num, name);
		end else begin
			fail_count++;
			$display("Test %0d %s: FAIL with %0d errors", num, name, test_errors);
		end
		test_errors = 0;
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial begin
		logic [31:0] rnd;
		reset_sclk  = 1'b1;
		ctrl_in     = '0;
		pipe_read   = 1'b0;
		test_errors = 0;
		tbl_pf[0] = 24'hFFFFFF;	// All ones
		tbl_pa[0] = 24'hFFFFFF;
		tbl_sf[0] = 24'hFFFFFF;
		tbl_sa[0] = 24'hFFFFFF;
		tbl_pf[1] = 24'hAAAAAA;	// Alternating
		tbl_pa[1] = 24'h555555;
		tbl_sf[1] = 24'hAAAAAA;
		tbl_sa[1] = 24'h555555;
		for (int i = 2; i < TABLE_LEN; i++) begin
			rnd = $random(seed);
			tbl_pf[i] = rnd[23:0];
			rnd = $random(seed);
			tbl_pa[i] = rnd[23:0];
			rnd = $random(seed);
			tbl_sf[i] = rnd[23:0];
			rnd = $random(seed);
			tbl_sa[i] = rnd[23:0];
		end
		repeat (5) @(posedge okClk);
		reset_sclk <= 1'b0;
		@(negedge okClk);

		check_bit(pipe_ready, 1'b0, "pipe_ready");
		check_bit(overflow, 1'b0, "overflow");
		check_bit(sclk_out, 1'b0, "sclk_out");
		check_bit(start, 1'b0, "start");
		if (led !== 4'b1110) begin	// Only power LED lit
			$display("Error at %0t ns: led is %b, expected 1110", $time, led);
			test_errors++;
		end
		check_bit(clk_out, 1'b0, "clk_out with okClk low");
		@(posedge okClk);
		#25;	// Middle of the high phase
		check_bit(clk_out, 1'b1, "clk_out with okClk high");
		end_test(1, "reset values");

		set_ctrl(3'b011);	// Collect and read
		check_bit(start, 1'b1, "start");
		check_bit(led[2], 1'b0, "led[2] while collecting");
		check_bit(led[3], 1'b0, "led[3] with reads enabled");
		send_frames(0, 4);
		wait_ready();
		read_block(0);
		end_test(2, "capture and read back");

		send_frames(4, 3);
		check_bit(pipe_ready, 1'b0, "pipe_ready after three frames");
		send_frames(7, 1);
		check_bit(pipe_ready, 1'b1, "pipe_ready after four frames");
		read_block(4);
		check_bit(pipe_ready, 1'b0, "pipe_ready after block read");
		end_test(3, "block threshold");

		set_ctrl(3'b001);	// Read only
		sclk_pulses = 0;
		for (int p = 0; p < SAMPLES_PER_BLOCK; p++) begin	// A full block if captured
			u_adc_model.pulse_drdy();
			repeat (2 * acoustics_pkg::BITS_PER_CH + 8) @(posedge okClk);	// Frame apart
		end
		@(negedge okClk);
		if (sclk_pulses != 0) begin
			$display("Error at %0t ns: %0d sclk pulses with collect off", $time, sclk_pulses);
			test_errors++;
		end
		check_bit(pipe_ready, 1'b0, "pipe_ready with collect off");
		end_test(4, "collect off");

		set_ctrl(3'b011);
		send_frames(0, acoustics_pkg::FIFO_DEPTH + 2);	// Last two dropped
		check_bit(overflow, 1'b1, "overflow");
		for (int b = 0; b < acoustics_pkg::FIFO_DEPTH / SAMPLES_PER_BLOCK; b++) begin
			read_block(b * SAMPLES_PER_BLOCK);
		end
		check_bit(pipe_ready, 1'b0, "pipe_ready with FIFO drained");
		send_frames(2, 4);	// Must come out ahead of any dropped frame
		wait_ready();
		read_block(2);
		end_test(5, "overflow");

		send_frames(0, 4);
		check_bit(pipe_ready, 1'b1, "pipe_ready before clear");
		set_ctrl(3'b111);
		check_bit(led[1], 1'b0, "led[1] during clear");
		check_bit(overflow, 1'b0, "overflow after clear");
		check_bit(pipe_ready, 1'b0, "pipe_ready after clear");
		set_ctrl(3'b011);
		check_bit(pipe_ready, 1'b0, "pipe_ready after clear release");
		send_frames(4, 4);
		wait_ready();
		read_block(4);
		end_test(6, "clear");

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// Watchdog sized from the frame count
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Regression failed");
		$finish;
	end

endmodule

// File: dv/adc_model.sv
// Behavioral four-channel ADC

`timescale 1ns/1ps

module adc_model (
	input  logic okClk,
	input  logic sclk,	// Gated bit clock from the DUT
	output logic drdy,	// Low while a frame is offered
	output logic miso_pf,
	output logic miso_pa,
	output logic miso_sf,
	output logic miso_sa
);

	initial begin
		drdy    = 1'b1;	// Idle high
		miso_pf = 1'b0;
		miso_pa = 1'b0;
		miso_sf = 1'b0;
		miso_sa = 1'b0;
	end

	// ------------------------------------------------------------------------
	// One frame, MSB first on every sclk rise
	// ------------------------------------------------------------------------
	task automatic send_frame(
		input logic [acoustics_pkg::BITS_PER_CH-1:0] pf,
		input logic [acoustics_pkg::BITS_PER_CH-1:0] pa,
		input logic [acoustics_pkg::BITS_PER_CH-1:0] sf,
		input logic [acoustics_pkg::BITS_PER_CH-1:0] sa
	);
		@(posedge okClk);
		drdy <= 1'b0;	// Sample ready
		for (int b = acoustics_pkg::BITS_PER_CH - 1; b >= 0; b--) begin
			@(posedge sclk);
			miso_pf <= pf[b];	// Stable until the sclk fall
			miso_pa <= pa[b];
			miso_sf <= sf[b];
			miso_sa <= sa[b];
		end
		@(negedge sclk);	// Last bit taken
		@(posedge okClk);
		drdy <= 1'b1;
		repeat (4) @(posedge okClk);	// Idle gap, sample lands in FIFO
	endtask

	// drdy fall with no data expected
	task automatic pulse_drdy();
		@(posedge okClk);
		drdy <= 1'b0;
		repeat (6) @(posedge okClk);
		drdy <= 1'b1;
		repeat (6) @(posedge okClk);
	endtask

endmodule

// File: filelist.f
rtl/acoustics_pkg.sv
rtl/acq_ctrl.sv
rtl/adc_capture.sv
rtl/sample_fifo.sv
rtl/pipe_unpacker.sv
rtl/acoustics_top.sv
dv/adc_model.sv
dv/acoustics_tb.sv

// File: rtl/acoustics_pkg.sv
// Acoustic capture shared definitions

package acoustics_pkg;

	// ------------------------------------------------------------------------
	// Frame geometry
	// ------------------------------------------------------------------------
	localparam int CHANNELS         = 4;	// PF, PA, SF, SA lanes
	localparam int BITS_PER_CH      = 24;	// Bits per lane per frame
	localparam int SAMPLE_W         = CHANNELS * BITS_PER_CH;	// 96-bit sample
	localparam int BIT_CNT_W        = $clog2(BITS_PER_CH);	// Bit counter width

	// ------------------------------------------------------------------------
	// Storage and host pipe
	// ------------------------------------------------------------------------
	localparam int WORD_W           = 32;	// Host pipe word
	localparam int WORDS_PER_SAMPLE = SAMPLE_W / WORD_W;	// Three words per sample
	localparam int WORD_IDX_W       = $clog2(WORDS_PER_SAMPLE);	// Word index width
	localparam int FIFO_DEPTH       = 16;	// Samples held
	localparam int PTR_W            = $clog2(FIFO_DEPTH);	// FIFO pointer width
	localparam int COUNT_W          = $clog2(FIFO_DEPTH + 1);	// Occupancy 0..DEPTH
	localparam int WAIT_W           = COUNT_W + 2;	// Words waiting, up to 48
	localparam int BLOCK_WORDS      = 12;	// Host block size in words

	// ------------------------------------------------------------------------
	// Control and indicators
	// ------------------------------------------------------------------------
	localparam int CTRL_W           = 3;	// read_en, collect, clear
	localparam int CTRL_READ_BIT    = 0;
	localparam int CTRL_COLLECT_BIT = 1;
	localparam int CTRL_CLEAR_BIT   = 2;
	localparam int LED_W            = 4;	// Board LEDs
	localparam int BLINK_W          = 24;	// Overflow blink divider

	// PF in the top field, SA in the bottom, each MSB first
	typedef logic [SAMPLE_W-1:0] sample_t;

	// Capture FSM
	typedef enum logic [1:0] {
		IDLE,	// Waiting for drdy fall
		SHIFT_HIGH,	// sclk high, ADC presents bit
		SHIFT_LOW,	// sclk low, bit taken
		DONE	// Sample strobe
	} capture_state_t;

endpackage

// File: rtl/acoustics_top.sv
// Acoustic capture front end top

`timescale 1ns/1ps

module acoustics_top (
	input  logic                               okClk,
	input  logic                               reset_sclk,
	input  logic [acoustics_pkg::CTRL_W-1:0]   ctrl_in,	// read_en, collect, clear
	input  logic                               drdy_in,
	input  logic                               miso_pf_in,
	input  logic                               miso_pa_in,
	input  logic                               miso_sf_in,
	input  logic                               miso_sa_in,
	input  logic                               pipe_read,
	output logic                               sclk_out,
	output logic                               start,	// ADC converts while high
	output logic                               clk_out,	// ADC master clock
	output logic [acoustics_pkg::WORD_W-1:0]   pipe_data,
	output logic                               pipe_ready,
	output logic                               overflow,
	output logic [acoustics_pkg::LED_W-1:0]    led
);

	logic                              collect_en;
	logic                              read_en;
	logic                              clear;
	logic                              sample_valid;
	acoustics_pkg::sample_t            sample;
	acoustics_pkg::sample_t            head;
	logic [acoustics_pkg::COUNT_W-1:0] count;
	logic                              empty;
	logic                              pop;

	// ------------------------------------------------------------------------
	// Control
	// ------------------------------------------------------------------------
	acq_ctrl u_acq_ctrl (
		.okClk      (okClk),
		.reset_sclk (reset_sclk),
		.ctrl_in    (ctrl_in),
		.overflow   (overflow),
		.collect_en (collect_en),
		.read_en    (read_en),
		.clear      (clear),
		.led        (led)
	);

	assign start   = collect_en;	// Follows collect bit
	assign clk_out = okClk;	// Constant master clock

	// ------------------------------------------------------------------------
	// Capture path
	// ------------------------------------------------------------------------
	adc_capture u_adc_capture (
		.okClk        (okClk),
		.reset_sclk   (reset_sclk),
		.clear        (clear),
		.collect_en   (collect_en),
		.drdy_in      (drdy_in),
		.miso_pf_in   (miso_pf_in),
		.miso_pa_in   (miso_pa_in),
		.miso_sf_in   (miso_sf_in),
		.miso_sa_in   (miso_sa_in),
		.sclk_out     (sclk_out),
		.sample_valid (sample_valid),
		.sample       (sample)
	);

	sample_fifo u_sample_fifo (
		.okClk      (okClk),
		.reset_sclk (reset_sclk),
		.clear      (clear),
		.push       (sample_valid),
		.din        (sample),
		.pop        (pop),
		.head       (head),
		.count      (count),
		.empty      (empty),
		.overflow   (overflow)
	);

	// Host side
	pipe_unpacker u_pipe_unpacker (
		.okClk      (okClk),
		.reset_sclk (reset_sclk),
		.clear      (clear),
		.read_en    (read_en),
		.head       (head),
		.count      (count),
		.empty      (empty),
		.pipe_read  (pipe_read),
		.pop        (pop),
		.pipe_data  (pipe_data),
		.pipe_ready (pipe_ready)
	);

endmodule

// File: rtl/acq_ctrl.sv
// Host control register and LEDs

`timescale 1ns/1ps

module acq_ctrl (
	input  logic                              okClk,
	input  logic                              reset_sclk,
	input  logic [acoustics_pkg::CTRL_W-1:0]  ctrl_in,	// Host wire-in
	input  logic                              overflow,	// Sticky FIFO overflow
	output logic                              collect_en,	// Capture enable, also start
	output logic                              read_en,	// Host read enable
	output logic                              clear,	// Storage clear
	output logic [acoustics_pkg::LED_W-1:0]   led	// Active low
);

	logic [acoustics_pkg::CTRL_W-1:0]  ctrl_q;	// Registered control word
	logic [acoustics_pkg::BLINK_W-1:0] blink_cnt;	// Slow divider for overflow blink

	// ------------------------------------------------------------------------
	// Control word register
	// ------------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (reset_sclk) begin
			ctrl_q <= '0;	// All off after reset
		end else begin
			ctrl_q <= ctrl_in;	// One cycle behind host
		end
	end

	assign read_en    = ctrl_q[acoustics_pkg::CTRL_READ_BIT];
	assign collect_en = ctrl_q[acoustics_pkg::CTRL_COLLECT_BIT];
	assign clear      = ctrl_q[acoustics_pkg::CTRL_CLEAR_BIT];

	// Divider only runs while overflow is flagged
	always_ff @(posedge okClk) begin
		if (reset_sclk) begin
			blink_cnt <= '0;
		end else if (overflow) begin
			blink_cnt <= blink_cnt + 1'b1;	// Free run
		end else begin
			blink_cnt <= '0;	// Park so blink starts lit
		end
	end

	// ------------------------------------------------------------------------
	// LEDs, 0 is lit
	// ------------------------------------------------------------------------
	assign led[0] = 1'b0;	// Power indicator
	assign led[1] = ~clear;	// Clear held by host
	assign led[2] = ~collect_en;	// Collecting
	assign led[3] = overflow ? blink_cnt[acoustics_pkg::BLINK_W-1]	// Lost frames
	                         : ~read_en;	// Read enabled

endmodule

// File: rtl/adc_capture.sv
// Four-lane ADC serial capture

`timescale 1ns/1ps

module adc_capture (
	input  logic                   okClk,
	input  logic                   reset_sclk,
	input  logic                   clear,	// Abort frame, same as reset
	input  logic                   collect_en,	// Frames start only when set
	input  logic                   drdy_in,	// Falls when ADC has a sample
	input  logic                   miso_pf_in,
	input  logic                   miso_pa_in,
	input  logic                   miso_sf_in,
	input  logic                   miso_sa_in,
	output logic                   sclk_out,	// Gated bit clock
	output logic                   sample_valid,	// One cycle per frame
	output acoustics_pkg::sample_t sample
);

	acoustics_pkg::capture_state_t          state;
	logic [acoustics_pkg::BIT_CNT_W-1:0]    bit_cnt;	// Bit within frame
	logic                                   drdy_meta;	// Synchronizer stage 1
	logic                                   drdy_sync;	// Synchronizer stage 2
	logic                                   drdy_prev;	// Edge detect history
	logic                                   drdy_fall;
	logic                                   sclk_q;
	logic                                   valid_q;
	logic [acoustics_pkg::CHANNELS-1:0]     miso_bits;	// PF in the top bit
	acoustics_pkg::sample_t                 shift_q;	// Lane shift registers

	// ------------------------------------------------------------------------
	// drdy synchronizer and falling edge
	// ------------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (reset_sclk || clear) begin
			drdy_meta <= 1'b1;	// drdy idles high
			drdy_sync <= 1'b1;
			drdy_prev <= 1'b1;
		end else begin
			drdy_meta <= drdy_in;
			drdy_sync <= drdy_meta;
			drdy_prev <= drdy_sync;
		end
	end

	assign drdy_fall = drdy_prev & ~drdy_sync;	// High to low seen

	// ------------------------------------------------------------------------
	// Frame FSM, two cycles per bit
	// ------------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (reset_sclk || clear) begin
			state   <= acoustics_pkg::IDLE;
			bit_cnt <= '0;
			sclk_q  <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			case (state)
				acoustics_pkg::IDLE: begin
					if (drdy_fall && collect_en) begin	// Edges mid-frame never get here
						state   <= acoustics_pkg::SHIFT_HIGH;
						sclk_q  <= 1'b1;	// First rise
						bit_cnt <= '0;
					end
				end
				acoustics_pkg::SHIFT_HIGH: begin
					state  <= acoustics_pkg::SHIFT_LOW;
					sclk_q <= 1'b0;	// Fall, lanes taken at this edge
				end
				acoustics_pkg::SHIFT_LOW: begin
					if (bit_cnt == acoustics_pkg::BIT_CNT_W'(acoustics_pkg::BITS_PER_CH - 1)) begin
						state   <= acoustics_pkg::DONE;
						valid_q <= 1'b1;	// 48 cycles after first rise
					end else begin
						state   <= acoustics_pkg::SHIFT_HIGH;
						sclk_q  <= 1'b1;
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				acoustics_pkg::DONE: begin
					state   <= acoustics_pkg::IDLE;
					valid_q <= 1'b0;	// Single-cycle strobe
				end
				default: begin
					state <= acoustics_pkg::IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Lane shift, MSB first into each 24-bit field
	// ------------------------------------------------------------------------
	assign miso_bits = {miso_pf_in, miso_pa_in, miso_sf_in, miso_sa_in};

	always_ff @(posedge okClk) begin
		if (state == acoustics_pkg::SHIFT_HIGH) begin	// sclk falling
			for (int c = 0; c < acoustics_pkg::CHANNELS; c++) begin
				shift_q[c*acoustics_pkg::BITS_PER_CH +: acoustics_pkg::BITS_PER_CH] <=
					{shift_q[c*acoustics_pkg::BITS_PER_CH +: acoustics_pkg::BITS_PER_CH-1],
					 miso_bits[c]};
			end
		end
	end

	assign sclk_out     = sclk_q;
	assign sample_valid = valid_q;
	assign sample       = shift_q;	// Stable through DONE

endmodule

// File: rtl/pipe_unpacker.sv
// Sample to host word unpacker

`timescale 1ns/1ps

module pipe_unpacker (
	input  logic                               okClk,
	input  logic                               reset_sclk,
	input  logic                               clear,
	input  logic                               read_en,	// Host allows reads
	input  acoustics_pkg::sample_t             head,	// FIFO head sample
	input  logic [acoustics_pkg::COUNT_W-1:0]  count,	// Samples in FIFO
	input  logic                               empty,
	input  logic                               pipe_read,	// Host pop strobe
	output logic                               pop,	// Release head sample
	output logic [acoustics_pkg::WORD_W-1:0]   pipe_data,	// Show-ahead word
	output logic                               pipe_ready	// Block waiting
);

	logic [acoustics_pkg::WORD_IDX_W-1:0] word_idx;	// Word of head on the pipe
	logic                                 advance;
	logic                                 last_word;
	logic [acoustics_pkg::WAIT_W-1:0]     words_waiting;
	logic                                 ready_q;

	// ------------------------------------------------------------------------
	// Word select, word 0 is the top of the sample
	// ------------------------------------------------------------------------
	assign pipe_data = head[(acoustics_pkg::WORDS_PER_SAMPLE - 1 - int'(word_idx))
	                        * acoustics_pkg::WORD_W +: acoustics_pkg::WORD_W];

	assign advance   = pipe_read & ~empty;	// Reads on empty ignored
	assign last_word = (word_idx ==
	                    acoustics_pkg::WORD_IDX_W'(acoustics_pkg::WORDS_PER_SAMPLE - 1));
	assign pop       = advance & last_word;	// Third word consumed

	always_ff @(posedge okClk) begin
		if (reset_sclk || clear) begin
			word_idx <= '0;
		end else if (advance) begin
			if (last_word) begin
				word_idx <= '0;	// Next sample becomes head
			end else begin
				word_idx <= word_idx + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Block ready
	// ------------------------------------------------------------------------
	// Whole samples less the words of the head already read
	assign words_waiting = acoustics_pkg::WAIT_W'(count)
	                       * acoustics_pkg::WAIT_W'(acoustics_pkg::WORDS_PER_SAMPLE)
	                       - acoustics_pkg::WAIT_W'(word_idx);

	always_ff @(posedge okClk) begin
		if (reset_sclk || clear) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= read_en &&
			           (words_waiting >= acoustics_pkg::WAIT_W'(acoustics_pkg::BLOCK_WORDS));
		end
	end

	assign pipe_ready = ready_q;

endmodule

// File: rtl/sample_fifo.sv
// Sample FIFO with overflow flag

`timescale 1ns/1ps

module sample_fifo (
	input  logic                               okClk,
	input  logic                               reset_sclk,
	input  logic                               clear,	// Empty and drop overflow
	input  logic                               push,
	input  acoustics_pkg::sample_t             din,
	input  logic                               pop,
	output acoustics_pkg::sample_t             head,	// Show-ahead
	output logic [acoustics_pkg::COUNT_W-1:0]  count,
	output logic                               empty,
	output logic                               overflow	// Sticky
);

	acoustics_pkg::sample_t                mem [acoustics_pkg::FIFO_DEPTH];
	logic [acoustics_pkg::PTR_W-1:0]       wr_ptr;
	logic [acoustics_pkg::PTR_W-1:0]       rd_ptr;
	logic [acoustics_pkg::COUNT_W-1:0]     count_q;
	logic                                  overflow_q;
	logic                                  full;
	logic                                  do_push;
	logic                                  do_pop;

	assign full    = (count_q == acoustics_pkg::COUNT_W'(acoustics_pkg::FIFO_DEPTH));
	assign empty   = (count_q == '0);
	assign do_push = push & ~full;	// Dropped when full
	assign do_pop  = pop & ~empty;

	// ------------------------------------------------------------------------
	// Storage
	// ------------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (do_push) begin
			mem[wr_ptr] <= din;
		end
	end

	assign head = mem[rd_ptr];

	// ------------------------------------------------------------------------
	// Pointers, occupancy and overflow
	// ------------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (reset_sclk || clear) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count_q    <= '0;
			overflow_q <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;	// Wraps at depth
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;	// Both or neither
			endcase
			if (push && full) begin
				overflow_q <= 1'b1;	// Frame lost
			end
		end
	end

	assign count    = count_q;
	assign overflow = overflow_q;

endmodule
